// File: hdl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data memory size in 32-bit words
`define MEM_DEPTH_WORDS 256

// cycles from the first request cycle to data_resp, at least 1
`define MEM_LATENCY 2

// major opcodes for the two memory instruction classes
`define OP_LOAD  7'b0000011
`define OP_STORE 7'b0100011

// opcode of register-immediate ALU instructions
`define OP_IMM   7'b0010011

// register-register ALU instructions
`define OP_REG   7'b0110011

`endif

// File: hdl/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

  localparam int FUNCT3_W = 3;
  localparam int REG_IDX_W = 5;

  // funct3 encodings shared by loads and stores
  localparam logic [FUNCT3_W-1:0] F3_B  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_H  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_W  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_BU = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_HU = 3'b101;

  // a load reads the word as I-format, a store as S-format
  typedef union packed {
    struct packed {
      logic [11:0]          imm;
      logic [REG_IDX_W-1:0] rs1;
      logic [FUNCT3_W-1:0]  funct3;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
    } i_fmt;
    struct packed {
      logic [6:0]           imm_hi;
      logic [REG_IDX_W-1:0] rs2;
      logic [REG_IDX_W-1:0] rs1;
      logic [FUNCT3_W-1:0]  funct3;
      logic [4:0]           imm_lo;
      logic [6:0]           opcode;
    } s_fmt;
  } rv32i_instr_u;

endpackage

`default_nettype wire

// File: hdl/mem_lane_pkg.sv
`default_nettype none

package mem_lane_pkg;

  import rv32i_isa_pkg::*;

  // byte enables for a store of the given size at the given offset
  function automatic logic [3:0] store_mask(input logic [FUNCT3_W-1:0] funct3,
                                            input logic [1:0] addr_lo);
    case (funct3)
      F3_B:    return 4'b0001 << addr_lo;
      F3_H:    return addr_lo[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // replicate the value over the word, then keep only the enabled lanes
  function automatic logic [31:0] store_lanes(input logic [FUNCT3_W-1:0] funct3,
                                              input logic [1:0] addr_lo,
                                              input logic [31:0] value);
    logic [31:0] rep;
    logic [3:0]  mask;
    case (funct3)
      F3_B:    rep = {4{value[7:0]}};
      F3_H:    rep = {2{value[15:0]}};
      default: rep = value;
    endcase
    mask = store_mask(funct3, addr_lo);
    return rep & {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  endfunction

  // pick the addressed byte or half and extend it
  function automatic logic [31:0] load_ext(input logic [FUNCT3_W-1:0] funct3,
                                           input logic [1:0] addr_lo,
                                           input logic [31:0] word);
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    byte_v = word[8*addr_lo +: 8];
    half_v = addr_lo[1] ? word[31:16] : word[15:0];
    case (funct3)
      F3_B:    return {{24{byte_v[7]}}, byte_v};
      F3_H:    return {{16{half_v[15]}}, half_v};
      F3_BU:   return {24'b0, byte_v};
      F3_HU:   return {16'b0, half_v};
      default: return word;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: hdl/store_align.sv
`default_nettype none

module store_align
  import rv32i_isa_pkg::*;
  import mem_lane_pkg::*;
(
  input  wire logic [FUNCT3_W-1:0] funct3,
  input  wire logic [1:0]          addr_lo,
  input  wire logic [31:0]         store_value,
  output logic      [3:0]          mbe,
  output logic      [31:0]         wdata
);

  logic [3:0]  lane_mask;
  logic [31:0] lane_word;

  // enables and lane data come from the same size decode
  always_comb begin
    lane_mask = store_mask(funct3, addr_lo);
    lane_word = store_lanes(funct3, addr_lo, store_value);
  end

  assign mbe   = lane_mask;
  assign wdata = lane_word;

  // a halfword at offset 3 would cross into the next word
  a_half_in_word: assert final (!(funct3 == F3_H && addr_lo == 2'b11))
    else $error("store_align: halfword store at offset 3");

endmodule

`default_nettype wire

// File: hdl/mem_forward_unit.sv
`default_nettype none

`include "mem_params.svh"

module mem_forward_unit
  import rv32i_isa_pkg::*;
(
  input  wire rv32i_instr_u instruction,
  input  wire logic         mem_write,
  input  wire rv32i_instr_u instruction_out,
  input  wire logic         load_regfile_out,
  input  wire logic [31:0]  alu_out,
  input  wire logic [31:0]  alu_out_out,
  output logic              fwd
);

  logic store_here;
  logic load_in_wb;
  logic reg_match;
  logic word_match;

  assign store_here = mem_write && (instruction.s_fmt.opcode == `OP_STORE);
  assign load_in_wb = load_regfile_out && (instruction_out.i_fmt.opcode == `OP_LOAD);

  // x0 never carries a loaded value
  assign reg_match  = (instruction.s_fmt.rs2 == instruction_out.i_fmt.rd) &&
                      (instruction_out.i_fmt.rd != '0);
  assign word_match = (alu_out[31:2] == alu_out_out[31:2]);

  assign fwd = store_here && load_in_wb && reg_match && word_match;

endmodule

`default_nettype wire

// File: hdl/load_extend.sv
`default_nettype none

module load_extend
  import rv32i_isa_pkg::*;
  import mem_lane_pkg::*;
(
  input  wire logic [FUNCT3_W-1:0] funct3,
  input  wire logic [1:0]          addr_lo,
  input  wire logic [31:0]         rdata,
  output logic      [31:0]         value
);

  logic [31:0] ext;

  // LB, LH, LBU and LHU pick a lane; LW passes the word
  always_comb begin
    ext = load_ext(funct3, addr_lo, rdata);
  end

  assign value = ext;

endmodule

`default_nettype wire

// File: hdl/memory_access.sv
`default_nettype none

module memory_access
  import rv32i_isa_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] pc,
  input  wire logic [31:0] instruction,
  input  wire logic [31:0] alu_out,
  input  wire logic [31:0] rs2_value,
  input  wire logic        br_en,
  input  wire logic        mem_read,
  input  wire logic        mem_write,
  input  wire logic        load_regfile,
  input  wire logic [31:0] data_rdata,
  input  wire logic        data_resp,
  output logic      [31:0] data_addr,
  output logic      [31:0] data_wdata,
  output logic      [3:0]  data_mbe,
  output logic             data_read,
  output logic             data_write,
  output logic             ma_stall,
  output logic      [31:0] pc_out,
  output logic      [31:0] pc_plus4_out,
  output logic      [31:0] instruction_out,
  output logic      [31:0] alu_out_out,
  output logic             br_en_out,
  output logic             load_regfile_out,
  output logic      [31:0] rd_load_data
);

  rv32i_instr_u        instr_u;
  logic [FUNCT3_W-1:0] funct3;
  logic [1:0]          store_lo;
  logic [31:0]         store_src;
  logic                fwd;
  logic [31:0]         rdata_q;
  logic [1:0]          addr_lo_q;
  logic [FUNCT3_W-1:0] funct3_q;

  assign instr_u = instruction;
  // funct3 sits at the same bits in the I and S views
  assign funct3  = instr_u.i_fmt.funct3;

  mem_forward_unit i_mem_forward_unit (
    .instruction      (instruction),
    .mem_write        (mem_write),
    .instruction_out  (instruction_out),
    .load_regfile_out (load_regfile_out),
    .alu_out          (alu_out),
    .alu_out_out      (alu_out_out),
    .fwd              (fwd)
  );

  // loaded value in write-back replaces a stale rs2
  assign store_src = fwd ? rd_load_data : rs2_value;
  // lane offset only matters for a store
  assign store_lo  = mem_write ? alu_out[1:0] : 2'b00;

  store_align i_store_align (
    .funct3      (funct3),
    .addr_lo     (store_lo),
    .store_value (store_src),
    .mbe         (data_mbe),
    .wdata       (data_wdata)
  );

  assign data_addr  = {alu_out[31:2], 2'b00};
  assign data_read  = mem_read;
  assign data_write = mem_write;
  assign ma_stall   = (mem_read || mem_write) && !data_resp;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_out           <= '0;
      pc_plus4_out     <= '0;
      instruction_out  <= '0;
      alu_out_out      <= '0;
      br_en_out        <= 1'b0;
      load_regfile_out <= 1'b0;
      rdata_q          <= '0;
      addr_lo_q        <= '0;
      funct3_q         <= '0;
    end else if (!ma_stall) begin
      pc_out           <= pc;
      pc_plus4_out     <= pc + 32'd4;
      instruction_out  <= instruction;
      alu_out_out      <= alu_out;
      br_en_out        <= br_en;
      load_regfile_out <= load_regfile;
      rdata_q          <= data_rdata;
      addr_lo_q        <= alu_out[1:0];
      funct3_q         <= funct3;
    end
  end

  load_extend i_load_extend (
    .funct3  (funct3_q),
    .addr_lo (addr_lo_q),
    .rdata   (rdata_q),
    .value   (rd_load_data)
  );

  a_one_request: assert property (@(posedge clk) disable iff (rst)
    !(data_read && data_write));

  // a stalled request stays on the bus until data_resp
  a_request_held: assert property (@(posedge clk) disable iff (rst)
    ma_stall |=> (data_read || data_write) && $stable(data_addr));

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`default_nettype none

`include "mem_params.svh"

module data_ram (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] addr,
  input  wire logic [31:0] wdata,
  input  wire logic [3:0]  mbe,
  input  wire logic        read,
  input  wire logic        write,
  output logic      [31:0] rdata,
  output logic             resp
);

  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  logic [31:0]      mem [`MEM_DEPTH_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic             req;
  logic             done;
  logic [IDX_W-1:0] idx;

  assign req  = read || write;
  assign idx  = addr[IDX_W+1:2];
  // last wait cycle, the access completes on this edge
  assign done = req && !resp && (wait_cnt == CNT_W'(`MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      resp     <= 1'b0;
    end else begin
      resp <= done;
      if (resp || done)
        wait_cnt <= '0;
      else if (req)
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (done && read)
      rdata <= mem[idx];
    if (done && write) begin
      for (int b = 0; b < 4; b++) begin
        if (mbe[b])
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
    resp |-> req);

endmodule

`default_nettype wire

// File: hdl/mem_stage_top.sv
`default_nettype none

module mem_stage_top (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] pc,
  input  wire logic [31:0] instruction,
  input  wire logic [31:0] alu_out,
  input  wire logic [31:0] rs2_value,
  input  wire logic        br_en,
  input  wire logic        mem_read,
  input  wire logic        mem_write,
  input  wire logic        load_regfile,
  output logic      [31:0] pc_out,
  output logic      [31:0] pc_plus4_out,
  output logic      [31:0] instruction_out,
  output logic      [31:0] alu_out_out,
  output logic             br_en_out,
  output logic             load_regfile_out,
  output logic      [31:0] rd_load_data,
  output logic             ma_stall
);

  // request and response between the stage and the memory
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_mbe;
  logic        data_read;
  logic        data_write;
  logic [31:0] data_rdata;
  logic        data_resp;

  memory_access i_memory_access (
    .clk              (clk),
    .rst              (rst),
    .pc               (pc),
    .instruction      (instruction),
    .alu_out          (alu_out),
    .rs2_value        (rs2_value),
    .br_en            (br_en),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .load_regfile     (load_regfile),
    .data_rdata       (data_rdata),
    .data_resp        (data_resp),
    .data_addr        (data_addr),
    .data_wdata       (data_wdata),
    .data_mbe         (data_mbe),
    .data_read        (data_read),
    .data_write       (data_write),
    .ma_stall         (ma_stall),
    .pc_out           (pc_out),
    .pc_plus4_out     (pc_plus4_out),
    .instruction_out  (instruction_out),
    .alu_out_out      (alu_out_out),
    .br_en_out        (br_en_out),
    .load_regfile_out (load_regfile_out),
    .rd_load_data     (rd_load_data)
  );

  data_ram i_data_ram (
    .clk   (clk),
    .rst   (rst),
    .addr  (data_addr),
    .wdata (data_wdata),
    .mbe   (data_mbe),
    .read  (data_read),
    .write (data_write),
    .rdata (data_rdata),
    .resp  (data_resp)
  );

endmodule

`default_nettype wire

// File: sim/tb_mem_stage.sv
`default_nettype none

`include "mem_params.svh"

module tb_mem_stage
  import rv32i_isa_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
  localparam logic [31:0] WIN_BASE = 32'h0000_0200;
  localparam int NUM_MIXED = 60;
  // fill stores plus up to three instructions per mixed step
  localparam int MAX_INSTR = 16 + 3 * NUM_MIXED;
  localparam int TIMEOUT_CYCLES = MAX_INSTR * (`MEM_LATENCY + 1) * 4 + 16;

  logic clk = 1'b0;
  logic rst;
  logic [31:0] pc, instruction, alu_out, rs2_value;
  logic br_en, mem_read, mem_write, load_regfile;
  logic [31:0] pc_out, pc_plus4_out, instruction_out, alu_out_out, rd_load_data;
  logic br_en_out, load_regfile_out, ma_stall;

  // reference model of memory contents and the write-back register
  logic [31:0] shadow [`MEM_DEPTH_WORDS];
  logic [31:0] exp_pc, exp_pc4, exp_instr, exp_alu, exp_load;
  logic        exp_br, exp_lr, exp_is_load;
  logic [4:0]  exp_rd;
  logic [31:0] rng = 32'h2fc6;
  logic [31:0] next_pc = 32'h0000_1000;
  int          cycle_count = 0;

  mem_stage_top i_dut (
    .clk              (clk),
    .rst              (rst),
    .pc               (pc),
    .instruction      (instruction),
    .alu_out          (alu_out),
    .rs2_value        (rs2_value),
    .br_en            (br_en),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .load_regfile     (load_regfile),
    .pc_out           (pc_out),
    .pc_plus4_out     (pc_plus4_out),
    .instruction_out  (instruction_out),
    .alu_out_out      (alu_out_out),
    .br_en_out        (br_en_out),
    .load_regfile_out (load_regfile_out),
    .rd_load_data     (rd_load_data),
    .ma_stall         (ma_stall)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the stage did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // byte, half or word written into the old word at the given offset
  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [2:0] f3,
                                              input logic [1:0] lo, input logic [31:0] val);
    logic [31:0] w;
    w = old;
    if (f3 == F3_B)
      w[8*lo +: 8] = val[7:0];
    else if (f3 == F3_H)
      w[16*lo[1] +: 16] = val[15:0];
    else
      w = val;
    return w;
  endfunction

  function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [1:0] lo,
                                              input logic [31:0] w);
    logic [31:0] sh;
    sh = w >> (8 * lo);
    case (f3)
      F3_B:    return {{24{sh[7]}}, sh[7:0]};
      F3_BU:   return {24'h0, sh[7:0]};
      F3_H:    return {{16{sh[15]}}, sh[15:0]};
      F3_HU:   return {16'h0, sh[15:0]};
      default: return w;
    endcase
  endfunction

  // legal offset for the access size
  function automatic logic [1:0] offset_for(input logic [2:0] f3, input logic [31:0] r);
    if (f3[1:0] == 2'b00)
      return r[1:0];
    else if (f3[1:0] == 2'b01)
      return {r[1], 1'b0};
    return 2'b00;
  endfunction

  function automatic logic [31:0] load_instr(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [31:0] r);
    rv32i_instr_u iu;
    iu.i_fmt.imm    = r[31:20];
    iu.i_fmt.rs1    = r[19:15];
    iu.i_fmt.funct3 = f3;
    iu.i_fmt.rd     = rd;
    iu.i_fmt.opcode = `OP_LOAD;
    return iu;
  endfunction

  function automatic logic [31:0] store_instr(input logic [2:0] f3, input logic [4:0] rs2,
                                              input logic [31:0] r);
    rv32i_instr_u iu;
    iu.s_fmt.imm_hi = r[31:25];
    iu.s_fmt.rs2    = rs2;
    iu.s_fmt.rs1    = r[19:15];
    iu.s_fmt.funct3 = f3;
    iu.s_fmt.imm_lo = r[11:7];
    iu.s_fmt.opcode = `OP_STORE;
    return iu;
  endfunction

  function automatic logic [2:0] load_kind(input int k);
    case (k % 5)
      0:       return F3_B;
      1:       return F3_H;
      2:       return F3_W;
      3:       return F3_BU;
      default: return F3_HU;
    endcase
  endfunction

  function automatic logic [2:0] store_kind(input logic [31:0] r);
    case (r % 3)
      0:       return F3_B;
      1:       return F3_H;
      default: return F3_W;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_eq("pc_out", exp_pc, pc_out);
    check_eq("pc_plus4_out", exp_pc4, pc_plus4_out);
    check_eq("instruction_out", exp_instr, instruction_out);
    check_eq("alu_out_out", exp_alu, alu_out_out);
    check_eq("br_en_out", {31'h0, exp_br}, {31'h0, br_en_out});
    check_eq("load_regfile_out", {31'h0, exp_lr}, {31'h0, load_regfile_out});
    if (exp_is_load)
      check_eq("rd_load_data", exp_load, rd_load_data);
  endtask

  // called right after a falling edge, returns right after a falling edge
  task automatic apply_instr(input logic [31:0] instr_w, input logic [31:0] addr,
                             input logic [31:0] rs2v, input logic rd_en, input logic wr_en,
                             input logic lr);
    rv32i_instr_u    iu;
    int              stalls;
    logic            fwd;
    logic            br;
    logic [31:0]     br_rand;
    logic [31:0]     wval;
    logic [IDX_W-1:0] idx;
    iu = instr_w;
    idx = addr[IDX_W+1:2];
    br_rand = next_rand();
    br = br_rand[7];
    pc = next_pc;
    instruction = instr_w;
    alu_out = addr;
    rs2_value = rs2v;
    br_en = br;
    mem_read = rd_en;
    mem_write = wr_en;
    load_regfile = lr;
    #1;
    stalls = 0;
    while (ma_stall) begin
      stalls++;
      check_outputs();
      @(negedge clk);
    end
    check_eq("ma_stall cycles", (rd_en || wr_en) ? `MEM_LATENCY : 0, stalls);
    // store right behind a load of its rs2 at the same word takes the loaded value
    fwd = wr_en && exp_is_load && exp_lr && (iu.s_fmt.rs2 == exp_rd) && (exp_rd != 5'd0) &&
          (addr[31:2] == exp_alu[31:2]);
    if (wr_en) begin
      wval = fwd ? exp_load : rs2v;
      shadow[idx] = merge_store(shadow[idx], iu.s_fmt.funct3, addr[1:0], wval);
    end
    if (rd_en)
      exp_load = extend_load(iu.i_fmt.funct3, addr[1:0], shadow[idx]);
    exp_is_load = rd_en;
    exp_rd = iu.i_fmt.rd;
    exp_pc = next_pc;
    exp_pc4 = next_pc + 32'd4;
    exp_instr = instr_w;
    exp_alu = addr;
    exp_br = br;
    exp_lr = lr;
    next_pc = next_pc + 32'd4;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic forward_pair(input int k);
    logic [31:0] r;
    logic [31:0] word_addr;
    logic [2:0]  lf3;
    logic [2:0]  sf3;
    logic [4:0]  rd;
    r = next_rand();
    lf3 = load_kind(k);
    sf3 = store_kind(r >> 9);
    rd = 5'd1 + r[7:4];
    word_addr = WIN_BASE + {r[3:0], 2'b00};
    apply_instr(load_instr(lf3, rd, r), word_addr + offset_for(lf3, r >> 12), 32'h0, 1, 0, 1);
    apply_instr(store_instr(sf3, rd, r), word_addr + offset_for(sf3, r >> 14), next_rand(),
                0, 1, 0);
    apply_instr(load_instr(F3_W, r[20:16], r), word_addr, 32'h0, 1, 0, 1);
  endtask

  initial begin
    logic [31:0] r;
    logic [2:0]  f3;
    rst = 1'b1;
    {pc, instruction, alu_out, rs2_value} = '0;
    {br_en, mem_read, mem_write, load_regfile} = '0;
    {exp_pc, exp_pc4, exp_instr, exp_alu, exp_load} = '0;
    {exp_br, exp_lr, exp_is_load, exp_rd} = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_outputs();
    check_eq("rd_load_data", 32'h0, rd_load_data);
    check_eq("ma_stall", 32'h0, {31'h0, ma_stall});

    // give every word of the window a known value
    for (int w = 0; w < 16; w++) begin
      r = next_rand();
      apply_instr(store_instr(F3_W, r[24:20], r), WIN_BASE + 4 * w, next_rand(), 0, 1, 0);
    end

    for (int i = 0; i < NUM_MIXED; i++) begin
      r = next_rand();
      if (i % 6 == 5) begin
        forward_pair(i / 6);
      end else if (r[2:0] < 3'd2) begin
        apply_instr({r[31:7], r[8] ? `OP_REG : `OP_IMM}, next_rand(), next_rand(), 0, 0, 1);
      end else if (r[2:0] < 3'd5) begin
        f3 = load_kind(r[31:28]);
        apply_instr(load_instr(f3, r[12:8], r),
                    WIN_BASE + {r[16:13], 2'b00} + offset_for(f3, r >> 20), 32'h0, 1, 0, 1);
      end else begin
        f3 = store_kind(r >> 24);
        apply_instr(store_instr(f3, r[12:8], r),
                    WIN_BASE + {r[16:13], 2'b00} + offset_for(f3, r >> 20), next_rand(),
                    0, 1, 0);
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/rv32i_isa_pkg.sv
hdl/mem_lane_pkg.sv
hdl/store_align.sv
hdl/mem_forward_unit.sv
hdl/load_extend.sv
hdl/memory_access.sv
hdl/data_ram.sv
hdl/mem_stage_top.sv
sim/tb_mem_stage.sv
